/* rtl/spiBridgePkg.sv */
`default_nettype none

package spiBridgePkg;

  // Command opcodes, first byte of every transaction
  localparam logic [7:0] opEcho     = 8'h11;
  localparam logic [7:0] opMemWrite = 8'h12;
  localparam logic [7:0] opMemRead  = 8'h13;
  localparam logic [7:0] opGpioDir  = 8'h14;
  localparam logic [7:0] opGpioData = 8'h15;

  localparam logic [7:0] ackOffset = 8'h11; // Ack is opcode plus this

  // Address field carries a full SPI address byte
  localparam int memAddrBits = 8;

  typedef enum logic [3:0] {
    sIdle,
    sCmd,
    sEcho,
    sWriteAddr,
    sWriteData,
    sReadAddr,
    sReadData,
    sGpioDir,
    sGpioData,
    sSkip
  } engineState_t;

  typedef struct packed {
    logic [7:0] data;
    logic       first; // First byte since csN fell
  } rxByte_t;

  typedef struct packed {
    logic                   we;
    logic [memAddrBits-1:0] addr; // Upper bits zero above ADDR_WIDTH
    logic [7:0]             wdata;
  } memAccess_t;

endpackage

`default_nettype wire

/* rtl/spiSlave.sv */
`timescale 1ns/10ps
`default_nettype none

module spiSlave
  import spiBridgePkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       sclk,
  input  logic       mosi,
  input  logic       csN,
  output logic       miso,
  output logic       rxValid,
  output rxByte_t    rx,
  output logic       csActive,
  input  logic       txLoad,
  input  logic [7:0] txByte
);

  logic [1:0] sclkSync;
  logic [1:0] mosiSync;
  logic [1:0] csNSync;
  logic       sclkPrev;
  logic       sclkRise;
  logic       sclkFall;
  logic [2:0] bitCnt;
  logic [6:0] rxShift;
  logic       firstPend;
  logic [7:0] txShift;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      sclkSync <= '0;
      mosiSync <= '0;
      csNSync  <= '1;   // Deselected
      sclkPrev <= 1'b0;
    end
    else
    begin
      sclkSync <= {sclkSync[0], sclk};
      mosiSync <= {mosiSync[0], mosi};
      csNSync  <= {csNSync[0], csN};
      sclkPrev <= sclkSync[1];
    end
  end

  assign sclkRise = sclkSync[1] & ~sclkPrev;
  assign sclkFall = ~sclkSync[1] & sclkPrev;
  assign csActive = ~csNSync[1];

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      bitCnt    <= '0;
      firstPend <= 1'b1;
      rxValid   <= 1'b0;
    end
    else
    begin
      rxValid <= 1'b0;
      if (!csActive)
      begin
        bitCnt    <= '0;
        firstPend <= 1'b1;
      end
      else if (sclkRise)
      begin
        bitCnt <= bitCnt + 3'd1;
        if (bitCnt == 3'd7)
        begin
          rxValid   <= 1'b1;
          firstPend <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (csActive && sclkRise)
    begin
      rxShift <= {rxShift[5:0], mosiSync[1]};
      if (bitCnt == 3'd7)
      begin
        rx.data  <= {rxShift, mosiSync[1]};
        rx.first <= firstPend;
      end
    end
  end

  // The falling edge after bit 0 must keep the freshly loaded MSB
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      txShift <= '0;
    else if (!csActive)
      txShift <= '0;
    else if (txLoad)
      txShift <= txByte;
    else if (sclkFall && bitCnt != 3'd0)
      txShift <= {txShift[6:0], 1'b0}; // Zero fill when nothing is loaded
  end

  assign miso = txShift[7];

  // Host must hold csN low until the last byte has been taken in
  assert property (@(posedge clk) disable iff (!rstN) rxValid |-> csActive);

endmodule

`default_nettype wire

/* rtl/scratchRam.sv */
`timescale 1ns/10ps
`default_nettype none

module scratchRam
  import spiBridgePkg::*;
#(
  parameter int ADDR_WIDTH = 4
)
(
  input  logic       clk,
  input  memAccess_t mem,
  output logic [7:0] rdata
);

  logic [7:0] ram [2**ADDR_WIDTH];

  always_ff @(posedge clk)
  begin
    if (mem.we)
      ram[mem.addr[ADDR_WIDTH-1:0]] <= mem.wdata;
  end

  assign rdata = ram[mem.addr[ADDR_WIDTH-1:0]]; // Read without delay

endmodule

`default_nettype wire

/* rtl/gpioPort.sv */
`timescale 1ns/10ps
`default_nettype none

module gpioPort #(
  parameter int GPIO_WIDTH = 4
)
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [GPIO_WIDTH-1:0] gpioIn,
  input  logic                  dirWrite,
  input  logic                  dataWrite,
  input  logic [GPIO_WIDTH-1:0] wdata,
  output logic [GPIO_WIDTH-1:0] gpioOut,
  output logic [GPIO_WIDTH-1:0] gpioOe,
  output logic [GPIO_WIDTH-1:0] pins
);

  logic [GPIO_WIDTH-1:0] pinsMeta;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      gpioOe  <= '0; // All pins inputs
      gpioOut <= '0;
    end
    else
    begin
      if (dirWrite)
        gpioOe <= wdata;
      if (dataWrite)
        gpioOut <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      pinsMeta <= '0;
      pins     <= '0;
    end
    else
    begin
      pinsMeta <= gpioIn;
      pins     <= pinsMeta;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) !(dirWrite && dataWrite));

endmodule

`default_nettype wire

/* rtl/cmdEngine.sv */
`timescale 1ns/10ps
`default_nettype none

module cmdEngine
  import spiBridgePkg::*;
#(
  parameter int ADDR_WIDTH = 4,
  parameter int GPIO_WIDTH = 4
)
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  rxValid,
  input  rxByte_t               rx,
  input  logic                  csActive,
  output logic                  txLoad,
  output logic [7:0]            txByte,
  output memAccess_t            mem,
  input  logic [7:0]            rdata,
  output logic                  dirWrite,
  output logic                  dataWrite,
  output logic [GPIO_WIDTH-1:0] wdata,
  input  logic [GPIO_WIDTH-1:0] pins
);

  engineState_t          state;
  engineState_t          stateNext;
  logic [ADDR_WIDTH-1:0] addrCnt;
  logic [ADDR_WIDTH-1:0] addrSel;
  logic [7:0]            reply;
  logic                  dataByte;

  assign dataByte = rxValid & ~rx.first;

  // Address byte goes straight to the memory so the next reply is data
  assign addrSel = (state == sReadAddr) ? rx.data[ADDR_WIDTH-1:0] : addrCnt;

  assign mem.we    = dataByte && (state == sWriteData);
  assign mem.addr  = memAddrBits'(addrSel);
  assign mem.wdata = rx.data;

  assign dirWrite  = dataByte && (state == sGpioDir);
  assign dataWrite = dataByte && (state == sGpioData);
  assign wdata     = rx.data[GPIO_WIDTH-1:0];

  always_comb
  begin
    stateNext = state;
    reply     = 8'h00;
    if (!csActive)
      stateNext = sIdle;
    else if (rxValid && rx.first)
    begin
      reply = rx.data + ackOffset;
      case (rx.data)
        opEcho:     stateNext = sEcho;
        opMemWrite: stateNext = sWriteAddr;
        opMemRead:  stateNext = sReadAddr;
        opGpioDir:  stateNext = sGpioDir;
        opGpioData: stateNext = sGpioData;
        default:
        begin
          stateNext = sSkip; // Ignore until deselect
          reply     = 8'h00;
        end
      endcase
    end
    else if (rxValid)
    begin
      case (state)
        sEcho:      reply = rx.data;
        sWriteAddr: stateNext = sWriteData;
        sReadAddr:
        begin
          stateNext = sReadData;
          reply     = rdata;
        end
        sReadData:  reply = rdata;
        sGpioData:  reply = 8'(pins); // Pin readback
        default:    reply = 8'h00;
      endcase
    end
    else if (state == sIdle)
      stateNext = sCmd; // Selected, waiting for opcode
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state  <= sIdle;
      txLoad <= 1'b0;
    end
    else
    begin
      state  <= stateNext;
      txLoad <= rxValid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rxValid)
      txByte <= reply;
    if (dataByte)
    begin
      case (state)
        sWriteAddr:                       addrCnt <= rx.data[ADDR_WIDTH-1:0];
        sWriteData, sReadAddr, sReadData: addrCnt <= addrSel + ADDR_WIDTH'(1); // Wraps
        default:                          addrCnt <= addrCnt;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/spiBridge.sv */
`timescale 1ns/10ps
`default_nettype none

module spiBridge
  import spiBridgePkg::*;
#(
  parameter int ADDR_WIDTH = 4,
  parameter int GPIO_WIDTH = 4
)
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  sclk,
  input  logic                  mosi,
  input  logic                  csN,
  input  logic [GPIO_WIDTH-1:0] gpioIn,
  output logic                  miso,
  output logic [GPIO_WIDTH-1:0] gpioOut,
  output logic [GPIO_WIDTH-1:0] gpioOe
);

  logic                  rxValid;
  rxByte_t               rx;
  logic                  csActive;
  logic                  txLoad;
  logic [7:0]            txByte;
  memAccess_t            mem;
  logic [7:0]            rdata;
  logic                  dirWrite;
  logic                  dataWrite;
  logic [GPIO_WIDTH-1:0] gpioWdata;
  logic [GPIO_WIDTH-1:0] pins;

  spiSlave i_spiSlave (
    .clk      (clk),
    .rstN     (rstN),
    .sclk     (sclk),
    .mosi     (mosi),
    .csN      (csN),
    .miso     (miso),
    .rxValid  (rxValid),
    .rx       (rx),
    .csActive (csActive),
    .txLoad   (txLoad),
    .txByte   (txByte)
  );

  cmdEngine #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .GPIO_WIDTH (GPIO_WIDTH)
  ) i_cmdEngine (
    .clk       (clk),
    .rstN      (rstN),
    .rxValid   (rxValid),
    .rx        (rx),
    .csActive  (csActive),
    .txLoad    (txLoad),
    .txByte    (txByte),
    .mem       (mem),
    .rdata     (rdata),
    .dirWrite  (dirWrite),
    .dataWrite (dataWrite),
    .wdata     (gpioWdata),
    .pins      (pins)
  );

  scratchRam #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_scratchRam (
    .clk   (clk),
    .mem   (mem),
    .rdata (rdata)
  );

  gpioPort #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) i_gpioPort (
    .clk       (clk),
    .rstN      (rstN),
    .gpioIn    (gpioIn),
    .dirWrite  (dirWrite),
    .dataWrite (dataWrite),
    .wdata     (gpioWdata),
    .gpioOut   (gpioOut),
    .gpioOe    (gpioOe),
    .pins      (pins)
  );

endmodule

`default_nettype wire

/* testbench/spiHostTasks.svh */
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

logic [7:0]  mosiBytes [$]; // Bytes sent in one transaction
logic [7:0]  misoBytes [$]; // Replies captured on sclk rise
logic [31:0] rngState = 32'd17919;

function automatic logic [31:0] nextRandom();
  rngState = rngState ^ (rngState << 13);
  rngState = rngState ^ (rngState >> 17);
  rngState = rngState ^ (rngState << 5);
  return rngState;
endfunction

function automatic logic [7:0] randomByte();
  return 8'(nextRandom());
endfunction

// Leaves the caller 1 ns after a rising clk edge
task automatic stepCycles(input int n);
  repeat (n) @(posedge clk);
  #1;
endtask

// Mode 0, MSB first
task automatic shiftByte(input logic [7:0] txb, output logic [7:0] rxb);
  repeat (8)
  begin
    mosi = txb[7];
    txb  = txb << 1;
    stepCycles(cyclesPerBit / 2);
    sclk = 1'b1;
    rxb  = {rxb[6:0], miso}; // Sampled as sclk rises
    stepCycles(cyclesPerBit / 2);
    sclk = 1'b0;
  end
endtask

task automatic runTransaction();
  logic [7:0] got;
  misoBytes.delete();
  csN = 1'b0;
  stepCycles(csSetup);
  foreach (mosiBytes[k])
  begin
    shiftByte(mosiBytes[k], got);
    misoBytes.push_back(got);
  end
  mosi = 1'b0;
  stepCycles(csHold); // Last byte reaches the engine
  csN = 1'b1;
  stepCycles(csGap);
endtask

`endif

/* testbench/tbSpiBridge.sv */
`timescale 1ns/10ps
`default_nettype none

module tbSpiBridge
  import spiBridgePkg::*;
();

  localparam int addrWidth     = 4;
  localparam int gpioWidth     = 4;
  localparam int memDepth      = 2 ** addrWidth;
  localparam int resetCycles   = 5;
  localparam int cyclesPerBit  = 8;
  localparam int csSetup       = 4;
  localparam int csHold        = 8;
  localparam int csGap         = 8;
  localparam int numTxn        = 10;
  localparam int totalBytes    = 68; // Longest case of every transaction added up
  localparam int timeoutCycles =
    resetCycles + 2 * (totalBytes * 8 * cyclesPerBit + numTxn * (csSetup + csHold + csGap));

  logic                 clk = 1'b0;
  logic                 rstN;
  logic                 sclk;
  logic                 mosi;
  logic                 csN;
  logic                 miso;
  logic [gpioWidth-1:0] gpioIn;
  logic [gpioWidth-1:0] gpioOut;
  logic [gpioWidth-1:0] gpioOe;
  logic [7:0]           refMem [memDepth];
  logic                 refValid [memDepth]; // Cell written at least once
  logic                 dirSeen;
  int                   cycleCount = 0;

  `include "spiHostTasks.svh"

  spiBridge #(
    .ADDR_WIDTH (addrWidth),
    .GPIO_WIDTH (gpioWidth)
  ) i_spiBridge (
    .clk     (clk),
    .rstN    (rstN),
    .sclk    (sclk),
    .mosi    (mosi),
    .csN     (csN),
    .gpioIn  (gpioIn),
    .miso    (miso),
    .gpioOut (gpioOut),
    .gpioOe  (gpioOe)
  );

  always
  begin
    #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles)
      failRun($sformatf("Timeout: simulation still running after %0d cycles", cycleCount));
  end

  // Pins stay inputs until the first direction write
  assert property (@(posedge clk) disable iff (!rstN) !dirSeen |-> (gpioOe == '0))
  else failRun($sformatf("MISMATCH at %0t: gpioOe expected 0x0 got 0x%0h", $time, gpioOe));

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkByte(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
    assert (actual === expected)
    else failRun($sformatf("MISMATCH at %0t: %s expected 0x%02h got 0x%02h",
                           $time, name, expected, actual));
  endtask

  task automatic expectAck(input logic [7:0] ack);
    checkByte("miso first reply", 8'h00, misoBytes[0]);
    checkByte("miso ack", ack, misoBytes[1]);
  endtask

  task automatic testEcho();
    mosiBytes.delete();
    mosiBytes.push_back(opEcho);
    repeat (5)
      mosiBytes.push_back(randomByte());
    runTransaction();
    expectAck(8'h22);
    for (int k = 2; k < mosiBytes.size(); k++)
      checkByte("miso echo", mosiBytes[k-1], misoBytes[k]);
  endtask

  task automatic testReadWindow(input logic [addrWidth-1:0] start, input int count);
    logic [addrWidth-1:0] addr;
    addr = start;
    mosiBytes.delete();
    mosiBytes.push_back(opMemRead);
    mosiBytes.push_back(8'(start));
    repeat (count)
      mosiBytes.push_back(randomByte());
    runTransaction();
    expectAck(8'h24);
    for (int k = 2; k < count + 2; k++)
    begin
      if (refValid[addr])
        checkByte($sformatf("miso mem[%0d]", addr), refMem[addr], misoBytes[k]);
      addr = addr + 1'b1;
    end
  endtask

  task automatic testBurst(input logic [addrWidth-1:0] base, input int len);
    logic [addrWidth-1:0] addr;
    logic [7:0]           data;
    addr = base;
    mosiBytes.delete();
    mosiBytes.push_back(opMemWrite);
    mosiBytes.push_back(8'(base));
    repeat (len)
    begin
      data = randomByte();
      mosiBytes.push_back(data);
      refMem[addr]   = data;
      refValid[addr] = 1'b1;
      addr           = addr + 1'b1; // Wraps at the top
    end
    runTransaction();
    expectAck(8'h23);
    testReadWindow(base - 1'b1, len + 2); // One cell either side
  endtask

  task automatic testGpio();
    logic [7:0]           dirByte;
    logic [7:0]           outByte;
    logic [gpioWidth-1:0] inVal;
    dirByte = randomByte();
    dirSeen = 1'b1;
    mosiBytes.delete();
    mosiBytes.push_back(opGpioDir);
    mosiBytes.push_back(dirByte);
    runTransaction();
    expectAck(8'h25);
    checkByte("gpioOe", 8'(dirByte[gpioWidth-1:0]), 8'(gpioOe));
    repeat (2)
    begin
      inVal  = gpioWidth'(nextRandom());
      gpioIn = inVal; // Held through the whole transaction
      mosiBytes.delete();
      mosiBytes.push_back(opGpioData);
      repeat (3)
      begin
        outByte = randomByte();
        mosiBytes.push_back(outByte);
      end
      runTransaction();
      expectAck(8'h26);
      for (int k = 2; k < 4; k++)
        checkByte("miso pins", 8'(inVal), misoBytes[k]);
      checkByte("gpioOut", 8'(outByte[gpioWidth-1:0]), 8'(gpioOut));
      checkByte("gpioOe", 8'(dirByte[gpioWidth-1:0]), 8'(gpioOe));
    end
  endtask

  task automatic testUnknown();
    logic [7:0]           cmd;
    logic [gpioWidth-1:0] oeBefore;
    logic [gpioWidth-1:0] outBefore;
    cmd = randomByte();
    if (cmd >= opEcho && cmd <= opGpioData)
      cmd = 8'hA5;
    oeBefore  = gpioOe;
    outBefore = gpioOut;
    mosiBytes.delete();
    mosiBytes.push_back(cmd);
    mosiBytes.push_back(opGpioDir); // Would act if decoded
    mosiBytes.push_back(8'(~oeBefore));
    mosiBytes.push_back(opMemWrite);
    mosiBytes.push_back(8'h00);
    mosiBytes.push_back(randomByte());
    runTransaction();
    foreach (misoBytes[k])
      checkByte("miso unknown", 8'h00, misoBytes[k]);
    checkByte("gpioOe", 8'(oeBefore), 8'(gpioOe));
    checkByte("gpioOut", 8'(outBefore), 8'(gpioOut));
  endtask

  initial
  begin
    logic [addrWidth-1:0] base;
    rstN     = 1'b0;
    sclk     = 1'b0;
    mosi     = 1'b0;
    csN      = 1'b1;
    gpioIn   = '0;
    dirSeen  = 1'b0;
    refValid = '{default: 1'b0};
    repeat (resetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;
    stepCycles(2);
    checkByte("miso", 8'h00, 8'(miso));
    checkByte("gpioOut", 8'h00, 8'(gpioOut));
    checkByte("gpioOe", 8'h00, 8'(gpioOe));
    testEcho();
    base = addrWidth'(nextRandom());
    testBurst(base, 1 + int'(nextRandom() % 32'd4));
    base = addrWidth'(memDepth - 1 - int'(nextRandom() % 32'd2)); // Last two cells
    testBurst(base, 4);
    testGpio();
    testUnknown();
    testReadWindow('0, memDepth); // Whole memory
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* spiBridge.f */
+incdir+testbench
rtl/spiBridgePkg.sv
rtl/spiSlave.sv
rtl/scratchRam.sv
rtl/gpioPort.sv
rtl/cmdEngine.sv
rtl/spiBridge.sv
testbench/tbSpiBridge.sv

/* run.sh */
#!/bin/sh
# Build and run the spiBridge testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert -j 0 --top-module tbSpiBridge -f spiBridge.f -o VtbSpiBridge
if [ $? -ne 0 ]
then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VtbSpiBridge > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Errors found" "$log"
then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]
then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation passed"
exit 0
